/* design/psgVoicePkg.sv */
`default_nettype none

// ==================================================
// channel side constants of the wave-table fetch
// ==================================================

package psgVoicePkg;

	// eight wave-table channels share the one system bus port
	localparam int NumChannels = 8;

	// a channel index has to cover every channel number
	localparam int ChanIdxWidth = 3;

	// system memory is addressed in sample sized words
	localparam int AddrWidth = 16;

	// a block is at most 255 samples long, a length of 0 means no block
	localparam int LenWidth = 8;

	// one wave-table sample as it comes off the bus
	localparam int SampleWidth = 16;

endpackage

`default_nettype wire

/* design/psgBusPkg.sv */
`default_nettype none

// ==================================================
// system bus side definitions
// ==================================================

package psgBusPkg;

	// width of the AXI read response field
	localparam int RespWidth = 2;

	// AXI response codes in their bus encoding
	typedef enum logic [RespWidth-1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axiResp;

	// read master states
	// Idle waits for a fresh grant, Addr holds the AR channel,
	// Data waits for the returned word
	typedef enum logic [1:0] {
		Idle = 2'd0,
		Addr = 2'd1,
		Data = 2'd2
	} readState;

endpackage

`default_nettype wire

/* design/psgWaveFetch.sv */
`timescale 1ns/1ps
`default_nettype none

// per-channel block bookkeeping
// each channel keeps the word address of its next sample and the number
// of samples it still has to fetch, and asks for the bus while that
// number is nonzero

module psgWaveFetch import psgVoicePkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	// host command, accepted on every cycle with cmdValid high
	input  logic                             cmdValid,
	input  logic [ChanIdxWidth-1:0]          cmdChan,
	input  logic [AddrWidth-1:0]             cmdBase,
	input  logic [LenWidth-1:0]              cmdLen,
	// one finished bus read and the channel it belonged to
	input  logic                             rdDone,
	input  logic [ChanIdxWidth-1:0]          rdChan,
	output logic [NumChannels-1:0]           req,
	output logic [NumChannels*AddrWidth-1:0] fetchAddr,
	output logic [NumChannels-1:0]           chanBusy
);

	// ==================================================
	// channel state
	// ==================================================

	logic [AddrWidth-1:0] addrReg [NumChannels];
	logic [LenWidth-1:0]  remain  [NumChannels];

	// high for a channel whose final sample is being reported right now
	logic [NumChannels-1:0] lastStep;

	// the remaining count is control state and starts at zero, so every
	// channel comes out of reset inactive
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumChannels; i++) begin
				remain[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NumChannels; i++) begin
				// a new command always wins, even over a read finishing
				// for the same channel in the same cycle
				if (cmdValid && cmdChan == ChanIdxWidth'(i)) begin
					remain[i] <= cmdLen;
				end else if (rdDone && rdChan == ChanIdxWidth'(i) && remain[i] != '0) begin
					remain[i] <= remain[i] - 1'b1;
				end
			end
		end
	end

	// word addresses follow the same rules as the count
	always_ff @(posedge clk) begin
		for (int i = 0; i < NumChannels; i++) begin
			if (cmdValid && cmdChan == ChanIdxWidth'(i)) begin
				addrReg[i] <= cmdBase;
			end else if (rdDone && rdChan == ChanIdxWidth'(i) && remain[i] != '0) begin
				addrReg[i] <= addrReg[i] + 1'b1;
			end
		end
	end

	// ==================================================
	// requests towards the arbiter
	// ==================================================

	// the read master is already idle in the cycle that reports a sample,
	// while the count only drops one cycle later
	// the request of a channel on its last sample is therefore dropped
	// early so the arbiter cannot hand it one read too many
	always_comb begin
		for (int i = 0; i < NumChannels; i++) begin
			lastStep[i] = rdDone && rdChan == ChanIdxWidth'(i) && remain[i] == LenWidth'(1);
			req[i]      = (remain[i] != '0) && !lastStep[i];
		end
	end

	// the host sees the same activity flags
	assign chanBusy = req;

	// flat address vector, channel 0 in the lowest bits
	always_comb begin
		for (int i = 0; i < NumChannels; i++) begin
			fetchAddr[i*AddrWidth +: AddrWidth] = addrReg[i];
		end
	end

endmodule

`default_nettype wire

/* design/psgBusArb.sv */
`timescale 1ns/1ps
`default_nettype none

// fixed priority bus arbiter for the wave-table channels
// channel 0 has the highest priority, and an owner is only replaced while
// the bus sits idle and the clock enable is high

module psgBusArb import psgVoicePkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	// slow clock enable of the sound generator
	input  logic                    ce,
	// the read master has no transfer in progress
	input  logic                    busIdle,
	input  logic [NumChannels-1:0]  req,
	// one-hot owner, owner index and a pulse for every fresh grant
	output logic [NumChannels-1:0]  sel,
	output logic [ChanIdxWidth-1:0] seln,
	output logic                    grantNew
);

	// ==================================================
	// priority pick
	// ==================================================

	logic [ChanIdxWidth-1:0] pickIdx;
	logic [NumChannels-1:0]  pickSel;
	logic                    anyReq;
	logic                    decide;

	// walk from the top channel down so the lowest requester is left in
	// pickIdx and pickSel at the end of the loop
	always_comb begin
		pickIdx = '0;
		pickSel = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				pickIdx = ChanIdxWidth'(i);
				pickSel = NumChannels'(1) << i;
			end
		end
	end

	assign anyReq = |req;

	// a grant that is still pulsing has not yet been taken up by the read
	// master, whose idle flag is one cycle behind it
	// deciding again in that cycle could move the owner away from the
	// channel the master is about to serve
	assign decide = ce && busIdle && !grantNew && anyReq;

	// ==================================================
	// owner registers
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			sel      <= '0;
			seln     <= '0;
			grantNew <= 1'b0;
		end else begin
			grantNew <= 1'b0;
			if (decide) begin
				sel      <= pickSel;
				seln     <= pickIdx;
				grantNew <= 1'b1;
			end
			// without a request the last owner stays in place and no
			// grant pulse is raised
		end
	end

endmodule

`default_nettype wire

/* design/psgReadMaster.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite read master
// every fresh grant turns into one single-beat read of the owner's
// current word, and the returned word leaves as a tagged sample

module psgReadMaster import psgVoicePkg::*, psgBusPkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	// grant from the arbiter
	input  logic                             grantNew,
	input  logic [ChanIdxWidth-1:0]          seln,
	// next word address of every channel
	input  logic [NumChannels*AddrWidth-1:0] fetchAddr,
	output logic                             busIdle,
	// AR channel
	output logic                             axiArValid,
	input  logic                             axiArReady,
	output logic [AddrWidth-1:0]             axiAraddr,
	// R channel
	input  logic                             axiRValid,
	output logic                             axiRReady,
	input  logic [SampleWidth-1:0]           axiRData,
	input  logic [RespWidth-1:0]             axiRResp,
	// completion back to the channel bookkeeping
	output logic                             rdDone,
	output logic [ChanIdxWidth-1:0]          rdChan,
	// sample output, no back-pressure
	output logic                             sampleValid,
	output logic [ChanIdxWidth-1:0]          sampleChan,
	output logic [SampleWidth-1:0]           sampleData,
	output logic                             sampleErr
);

	// ==================================================
	// transfer FSM
	// ==================================================

	readState state;

	// channel the current transfer belongs to
	logic [ChanIdxWidth-1:0] ownerChan;

	// the response code in its named form
	axiResp respCode;
	logic   respBad;

	assign respCode = axiResp'(axiRResp);
	// slave and decode errors both mark the sample as bad
	assign respBad  = (respCode == SLVERR) || (respCode == DECERR);

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= Idle;
			sampleValid <= 1'b0;
		end else begin
			// the sample strobe lasts exactly one cycle
			sampleValid <= 1'b0;
			case (state)
				Idle: begin
					if (grantNew) begin
						state <= Addr;
					end
				end
				Addr: begin
					// address and valid stay put until the slave takes them
					if (axiArReady) begin
						state <= Data;
					end
				end
				Data: begin
					if (axiRValid) begin
						sampleValid <= 1'b1;
						state       <= Idle;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// owner index and address are latched once per grant
	always_ff @(posedge clk) begin
		if (state == Idle && grantNew) begin
			ownerChan <= seln;
			axiAraddr <= fetchAddr[seln*AddrWidth +: AddrWidth];
		end
	end

	// returned word and its tag are captured on the R handshake
	always_ff @(posedge clk) begin
		if (state == Data && axiRValid) begin
			sampleChan <= ownerChan;
			sampleData <= axiRData;
			sampleErr  <= respBad;
		end
	end

	// ==================================================
	// outputs decoded from the state
	// ==================================================

	assign busIdle    = (state == Idle);
	assign axiArValid = (state == Addr);
	// R is accepted on any cycle of the Data state
	assign axiRReady  = (state == Data);

	// the completion strobe and the sample strobe are the same event
	assign rdDone = sampleValid;
	assign rdChan = sampleChan;

endmodule

`default_nettype wire

/* design/psgArbTop.sv */
`timescale 1ns/1ps
`default_nettype none

// bus-fetch subsystem of the wave-table generator
// channel bookkeeping feeds the arbiter, the arbiter feeds the read
// master, and finished reads step the channels again

module psgArbTop import psgVoicePkg::*, psgBusPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ce,
	// host command port
	input  logic                    cmdValid,
	input  logic [ChanIdxWidth-1:0] cmdChan,
	input  logic [AddrWidth-1:0]    cmdBase,
	input  logic [LenWidth-1:0]     cmdLen,
	// AXI4-Lite read towards system memory
	output logic                    axiArValid,
	input  logic                    axiArReady,
	output logic [AddrWidth-1:0]    axiAraddr,
	input  logic                    axiRValid,
	output logic                    axiRReady,
	input  logic [SampleWidth-1:0]  axiRData,
	input  logic [RespWidth-1:0]    axiRResp,
	// sample stream
	output logic                    sampleValid,
	output logic [ChanIdxWidth-1:0] sampleChan,
	output logic [SampleWidth-1:0]  sampleData,
	output logic                    sampleErr,
	// per channel activity for the host
	output logic [NumChannels-1:0]  chanBusy
);

	// ==================================================
	// internal nets
	// ==================================================

	logic [NumChannels-1:0]           req;
	logic [NumChannels*AddrWidth-1:0] fetchAddr;
	logic [NumChannels-1:0]           sel;
	logic [ChanIdxWidth-1:0]          seln;
	logic                             grantNew;
	logic                             busIdle;
	logic                             rdDone;
	logic [ChanIdxWidth-1:0]          rdChan;

	psgWaveFetch i_psgWaveFetch (
		.clk       (clk),
		.rst       (rst),
		.cmdValid  (cmdValid),
		.cmdChan   (cmdChan),
		.cmdBase   (cmdBase),
		.cmdLen    (cmdLen),
		.rdDone    (rdDone),
		.rdChan    (rdChan),
		.req       (req),
		.fetchAddr (fetchAddr),
		.chanBusy  (chanBusy)
	);

	// sel is the one-hot view of the owner, kept for bus monitoring
	psgBusArb i_psgBusArb (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.busIdle  (busIdle),
		.req      (req),
		.sel      (sel),
		.seln     (seln),
		.grantNew (grantNew)
	);

	psgReadMaster i_psgReadMaster (
		.clk         (clk),
		.rst         (rst),
		.grantNew    (grantNew),
		.seln        (seln),
		.fetchAddr   (fetchAddr),
		.busIdle     (busIdle),
		.axiArValid  (axiArValid),
		.axiArReady  (axiArReady),
		.axiAraddr   (axiAraddr),
		.axiRValid   (axiRValid),
		.axiRReady   (axiRReady),
		.axiRData    (axiRData),
		.axiRResp    (axiRResp),
		.rdDone      (rdDone),
		.rdChan      (rdChan),
		.sampleValid (sampleValid),
		.sampleChan  (sampleChan),
		.sampleData  (sampleData),
		.sampleErr   (sampleErr)
	);

endmodule

`default_nettype wire

/* tests/psgArb_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// bus protocol and arbitration checks, bound into the subsystem top

module psgArbSva import psgVoicePkg::*, psgBusPkg::*; (
	input logic                   clk,
	input logic                   rst,
	input logic                   axiArValid,
	input logic                   axiArReady,
	input logic [AddrWidth-1:0]   axiAraddr,
	input logic                   axiRReady,
	input logic                   busIdle,
	input logic                   grantNew,
	input logic [NumChannels-1:0] sel
);

	// the master state as it shows on the AR and R channels
	readState seenState;

	assign seenState = axiArValid ? Addr : (axiRReady ? Data : Idle);

	// an address offer may not move or vanish before the slave takes it
	arHold: assert property (@(posedge clk) disable iff (rst)
		axiArValid && !axiArReady |=> axiArValid && $stable(axiAraddr))
		else $error("AR valid or address changed before the handshake");

	// an accepted address moves the master straight into its data phase
	arToData: assert property (@(posedge clk) disable iff (rst)
		axiArValid && axiArReady |=> seenState == Data)
		else $error("master did not enter the data phase after the AR handshake");

	selOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("arbiter owner vector has more than one bit set");

	// a fresh grant is only made while the bus was idle
	grantAfterIdle: assert property (@(posedge clk) disable iff (rst)
		grantNew |-> $past(busIdle))
		else $error("grant made while a transfer was in progress");

endmodule

bind psgArbTop psgArbSva i_psgArbSva (
	.clk        (clk),
	.rst        (rst),
	.axiArValid (axiArValid),
	.axiArReady (axiArReady),
	.axiAraddr  (axiAraddr),
	.axiRReady  (axiRReady),
	.busIdle    (busIdle),
	.grantNew   (grantNew),
	.sel        (sel)
);

`default_nettype wire

/* tests/psgArbTb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the wave-table bus-fetch subsystem
// the stimulus file lists the tests, a small AXI4-Lite memory answers
// the reads and a reference model predicts the sample stream

module psgArbTb import psgVoicePkg::*, psgBusPkg::*; ();

	localparam int MaxTests    = 8;
	localparam int MaxCmds     = 32;
	localparam int MaxSamples  = 256;
	localparam int QuietCycles = 10;

	logic                    clk        = 1'b0;
	logic                    rst;
	logic                    ce;
	logic                    cmdValid;
	logic [ChanIdxWidth-1:0] cmdChan;
	logic [AddrWidth-1:0]    cmdBase;
	logic [LenWidth-1:0]     cmdLen;
	logic                    axiArValid;
	logic                    axiArReady = 1'b0;
	logic [AddrWidth-1:0]    axiAraddr;
	logic                    axiRValid  = 1'b0;
	logic                    axiRReady;
	logic [SampleWidth-1:0]  axiRData   = '0;
	logic [RespWidth-1:0]    axiRResp   = '0;
	logic                    sampleValid;
	logic [ChanIdxWidth-1:0] sampleChan;
	logic [SampleWidth-1:0]  sampleData;
	logic                    sampleErr;
	logic [NumChannels-1:0]  chanBusy;

	// test table filled from the stimulus file
	logic [8*16-1:0]         testName  [MaxTests];
	logic                    testBp    [MaxTests];
	int                      testExp   [MaxTests];
	int                      testFirst [MaxTests];
	int                      testCmds  [MaxTests];
	logic [ChanIdxWidth-1:0] cmdChanTab [MaxCmds];
	logic [AddrWidth-1:0]    cmdBaseTab [MaxCmds];
	logic [LenWidth-1:0]     cmdLenTab  [MaxCmds];
	int                      numTests;
	int                      numCmds;

	// predicted stream of the running test
	logic [ChanIdxWidth-1:0] expChan [MaxSamples];
	logic [SampleWidth-1:0]  expData [MaxSamples];
	logic                    expErr  [MaxSamples];
	logic                    expMore [MaxSamples];
	int                      expCount;
	logic [NumChannels-1:0]  neverBusy;

	int          failCount;
	int          testsOk;
	int          testsBad;
	int          cycleCount = 0;
	int          cycleLimit = 0;
	logic        limitSet   = 1'b0;
	logic        bpMode     = 1'b0;
	int          ceGap;
	logic [31:0] ceSeed     = 32'd49788;
	logic [31:0] memSeed    = 32'd49788;
	int          arDelay    = -1;
	int          rDelay     = 0;
	logic        rPending   = 1'b0;
	logic [AddrWidth-1:0] rAddr = '0;

	psgArbTop i_psgArbTop (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.cmdValid    (cmdValid),
		.cmdChan     (cmdChan),
		.cmdBase     (cmdBase),
		.cmdLen      (cmdLen),
		.axiArValid  (axiArValid),
		.axiArReady  (axiArReady),
		.axiAraddr   (axiAraddr),
		.axiRValid   (axiRValid),
		.axiRReady   (axiRReady),
		.axiRData    (axiRData),
		.axiRResp    (axiRResp),
		.sampleValid (sampleValid),
		.sampleChan  (sampleChan),
		.sampleData  (sampleData),
		.sampleErr   (sampleErr),
		.chanBusy    (chanBusy)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// wait states of the memory, zero unless the test asks for back-pressure
	function automatic int drawDelay();
		memSeed = lcgStep(memSeed);
		return bpMode ? int'(memSeed[17:16]) : 0;
	endfunction

	// ==================================================
	// AXI4-Lite memory model
	// ==================================================

	// a word reads as its address with the upper byte inverted,
	// and everything from 0xF000 up answers with a slave error
	always @(negedge clk) begin
		if (rst) begin
			axiArReady = 1'b0;
			axiRValid  = 1'b0;
			rPending   = 1'b0;
			arDelay    = -1;
		end else begin
			// ready stays high for one cycle and the master takes it at once
			if (axiArReady) begin
				axiArReady = 1'b0;
				rPending   = 1'b1;
				rDelay     = drawDelay();
			end else if (axiArValid && !rPending) begin
				if (arDelay < 0) begin
					arDelay = drawDelay();
				end
				if (arDelay == 0) begin
					axiArReady = 1'b1;
					rAddr      = axiAraddr;
				end
				arDelay = arDelay - 1;
			end
			// rready is high for the whole data phase, so valid lasts one cycle
			if (axiRValid) begin
				axiRValid = 1'b0;
				rPending  = 1'b0;
			end else if (rPending && axiRReady) begin
				if (rDelay == 0) begin
					axiRValid = 1'b1;
					axiRData  = rAddr ^ 16'hFF00;
					axiRResp  = (rAddr >= 16'hF000) ? SLVERR : OKAY;
				end else begin
					rDelay = rDelay - 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (limitSet && cycleCount >= cycleLimit) begin
			$display("timeout: the tests did not complete within %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	// ==================================================
	// stimulus file and reference model
	// ==================================================

	task automatic readStim();
		int              fd;
		int              n;
		string           line;
		logic [8*16-1:0] nameVal;
		int              bpVal;
		int              expVal;
		int              chanVal;
		int              lenVal;
		logic [AddrWidth-1:0] baseVal;
		numTests = 0;
		numCmds  = 0;
		fd = $fopen("tests/psgArb_stim.txt", "r");
		if (fd == 0) begin
			$display("the stimulus file tests/psgArb_stim.txt could not be opened");
			failCount++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// test header, the commands below it belong to this test
				if (n > 0 && line[0] == "T" && numTests < MaxTests) begin
					n = $sscanf(line, "T %s %d %d", nameVal, bpVal, expVal);
					testName[numTests]  = nameVal;
					testBp[numTests]    = (bpVal != 0);
					testExp[numTests]   = expVal;
					testFirst[numTests] = numCmds;
					testCmds[numTests]  = 0;
					numTests++;
				end else if (n > 0 && line[0] == "C" && numTests > 0 && numCmds < MaxCmds) begin
					n = $sscanf(line, "C %d %h %d", chanVal, baseVal, lenVal);
					cmdChanTab[numCmds] = ChanIdxWidth'(chanVal);
					cmdBaseTab[numCmds] = baseVal;
					cmdLenTab[numCmds]  = LenWidth'(lenVal);
					testCmds[numTests-1]++;
					numCmds++;
				end
			end
			$fclose(fd);
		end
	endtask

	// channels drain in ascending order, each one from its base upwards,
	// and a later command to a channel replaces its earlier block
	task automatic buildExpected(input int t);
		logic [AddrWidth-1:0]   base [NumChannels];
		logic [LenWidth-1:0]    len  [NumChannels];
		logic [NumChannels-1:0] anyCmd;
		logic [NumChannels-1:0] anyLen;
		logic [AddrWidth-1:0]   a;
		int                     j;
		anyCmd   = '0;
		anyLen   = '0;
		expCount = 0;
		for (int c = 0; c < NumChannels; c++) begin
			base[c] = '0;
			len[c]  = '0;
		end
		for (int k = 0; k < testCmds[t]; k++) begin
			j = testFirst[t] + k;
			base[cmdChanTab[j]]   = cmdBaseTab[j];
			len[cmdChanTab[j]]    = cmdLenTab[j];
			anyCmd[cmdChanTab[j]] = 1'b1;
			if (cmdLenTab[j] != '0) begin
				anyLen[cmdChanTab[j]] = 1'b1;
			end
		end
		// a channel only ever given length 0 must never look busy
		neverBusy = anyCmd & ~anyLen;
		for (int c = 0; c < NumChannels; c++) begin
			for (int i = 0; i < int'(len[c]); i++) begin
				a = base[c] + AddrWidth'(i);
				expChan[expCount] = ChanIdxWidth'(c);
				expData[expCount] = {~a[15:8], a[7:0]};
				expErr[expCount]  = (a >= 16'hF000);
				expMore[expCount] = (i < int'(len[c]) - 1);
				expCount++;
			end
		end
	endtask

	// ==================================================
	// test sequencing and checks
	// ==================================================

	task automatic driveCe();
		if (!bpMode) begin
			ce = 1'b1;
		end else if (ceGap > 0) begin
			ce = 1'b0;
			ceGap--;
		end else begin
			ce = 1'b1;
			ceSeed = lcgStep(ceSeed);
			ceGap  = int'(ceSeed[17:16]);
		end
	endtask

	task automatic checkSample(input int t, input int idx);
		assert (idx < expCount) else begin
			$display("%0s: extra sample from channel %0d after the block was complete",
				testName[t], sampleChan);
			failCount++;
		end
		if (idx < expCount) begin
			assert (sampleChan == expChan[idx]) else begin
				$display("[FAIL] %0s sample %0d channel: expected %0d, actual %0d",
					testName[t], idx, expChan[idx], sampleChan);
				failCount++;
			end
			assert (sampleData == expData[idx]) else begin
				$display("[FAIL] %0s sample %0d data: expected %h, actual %h",
					testName[t], idx, expData[idx], sampleData);
				failCount++;
			end
			assert (sampleErr == expErr[idx]) else begin
				$display("[FAIL] %0s sample %0d error flag: expected %b, actual %b",
					testName[t], idx, expErr[idx], sampleErr);
				failCount++;
			end
			assert (!expMore[idx] || chanBusy[expChan[idx]]) else begin
				$display("%0s: channel %0d went idle with samples still to fetch",
					testName[t], expChan[idx]);
				failCount++;
			end
		end
	endtask

	task automatic runTest(input int t);
		int got;
		int quiet;
		int failsBefore;
		failsBefore = failCount;
		bpMode = testBp[t];
		ceGap  = 0;
		buildExpected(t);
		assert (expCount == testExp[t]) else begin
			$display("[FAIL] %0s sample count: expected %0d from file, actual %0d from model",
				testName[t], testExp[t], expCount);
			failCount++;
		end
		// commands go in with ce low so that all of them compete at once
		for (int k = 0; k < testCmds[t]; k++) begin
			@(negedge clk);
			ce       = 1'b0;
			cmdValid = 1'b1;
			cmdChan  = cmdChanTab[testFirst[t] + k];
			cmdBase  = cmdBaseTab[testFirst[t] + k];
			cmdLen   = cmdLenTab[testFirst[t] + k];
		end
		@(negedge clk);
		cmdValid = 1'b0;
		got   = 0;
		quiet = 0;
		while (got < expCount || quiet < QuietCycles) begin
			driveCe();
			if (sampleValid) begin
				checkSample(t, got);
				got++;
			end
			if (got >= expCount) begin
				quiet++;
			end
			assert ((chanBusy & neverBusy) == '0) else begin
				$display("%0s: a channel started with length 0 became busy", testName[t]);
				failCount++;
			end
			@(negedge clk);
		end
		assert (chanBusy == '0) else begin
			$display("[FAIL] %0s chanBusy after the last sample: expected 00, actual %h",
				testName[t], chanBusy);
			failCount++;
		end
		if (failCount == failsBefore) begin
			testsOk++;
		end else begin
			testsBad++;
		end
		$display("test %0s: %0s, %0d of %0d samples", testName[t],
			(failCount == failsBefore) ? "ok" : "FAILED", got, expCount);
	endtask

	initial begin
		int totalSamples;
		int failsBefore;
		rst          = 1'b1;
		ce           = 1'b0;
		cmdValid     = 1'b0;
		cmdChan      = '0;
		cmdBase      = '0;
		cmdLen       = '0;
		ceGap        = 0;
		failCount    = 0;
		testsOk      = 0;
		testsBad     = 0;
		totalSamples = 0;
		readStim();
		assert (numTests > 0) else begin
			$display("the stimulus file holds no tests");
			failCount++;
		end
		for (int t = 0; t < numTests; t++) begin
			totalSamples += testExp[t];
		end
		cycleLimit = totalSamples * 12 + 200;
		limitSet   = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		failsBefore = failCount;
		// nothing may be moving straight out of reset
		assert (!sampleValid && !axiArValid && chanBusy == '0) else begin
			$display("[FAIL] reset outputs: expected 0 0 00, actual %b %b %h",
				sampleValid, axiArValid, chanBusy);
			failCount++;
		end
		if (failCount == failsBefore) begin
			testsOk++;
		end else begin
			testsBad++;
		end
		$display("test reset: %0s", (failCount == failsBefore) ? "ok" : "FAILED");
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		$display("tests run %0d, ok %0d, failed %0d, failed checks %0d",
			testsOk + testsBad, testsOk, testsBad, failCount);
		if (failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* psgArb.f */
design/psgVoicePkg.sv
design/psgBusPkg.sv
design/psgWaveFetch.sv
design/psgBusArb.sv
design/psgReadMaster.sv
design/psgArbTop.sv
tests/psgArb_sva.sv
tests/psgArbTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module psgArbTb \
	-f psgArb.f \
	-o VpsgArbTb

# a simulator error counts as a failed run
if ! ./obj_dir/VpsgArbTb > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi

/* tests/psgArb_stim.txt */
# T <name> <back-pressure 0/1> <expected sample count>
# C <channel> <base word address, hex> <length>, commands of the test above in issue order
T idle 0 0
T single 0 5
C 3 0100 5
T priority 0 12
C 6 2000 3
C 1 1000 4
C 4 3000 2
C 0 0800 3
T backpressure 1 12
C 6 2000 3
C 1 1000 4
C 4 3000 2
C 0 0800 3
T errorresp 0 6
C 2 effd 6
T zerorestart 0 5
C 2 4000 0
C 5 5000 6
C 5 5100 3
C 7 7000 2
